/* bench/KnightsTour_tb.sv */
`default_nettype none

module KnightsTour_tb
  import cmdPkg::*;
();

  localparam int BAUD_DIV       = 16;
  localparam int PWM_BITS       = 6;
  localparam int DRIVE_DUTY     = 40;
  localparam int TURN_PERIODS   = 2;
  localparam int SQUARE_PERIODS = 3;
  localparam int CAL_PERIODS    = 4;
  // Longest command here is well under 2000 cycles
  localparam int RESP_TIMEOUT   = 8000;
  // Three frame times of silence after a response
  localparam int QUIET_CYCLES   = 3 * 10 * BAUD_DIV;

  // Response byte and rising-edge counts of one command
  typedef struct packed {
    logic [7:0]  resp;
    logic [15:0] lft1;
    logic [15:0] lft2;
    logic [15:0] rght1;
    logic [15:0] rght2;
  } outcomeT;

  // One finished test on its way to the compare process
  typedef struct packed {
    logic [15:0] cmdWord;
    logic        gotResp;
    logic        extraResp;
    outcomeT     seen;
  } resultT;

  logic        clk = 1'b0;
  logic        rstN;
  logic        RX;
  logic        TX;
  logic        lftPwm1;
  logic        lftPwm2;
  logic        rghtPwm1;
  logic        rghtPwm2;
  logic        clearEdges;
  logic [3:0]  pwmNow;
  logic [3:0]  pwmPrev;
  logic [15:0] edgeCnt [4];
  resultT      resultQ [$];
  string       nameQ [$];
  resultT      cmpRes;
  outcomeT     cmpExp;
  string       cmpName;
  int          errBefore;
  int          testCount = 0;
  int          checkCount = 0;
  int          errorCount = 0;
  int          seed;
  logic        drainFailed;
  int unsigned assertFails;

  KnightsTour #(
    .BAUD_DIV(BAUD_DIV),
    .PWM_BITS(PWM_BITS),
    .DRIVE_DUTY(DRIVE_DUTY),
    .TURN_PERIODS(TURN_PERIODS),
    .SQUARE_PERIODS(SQUARE_PERIODS),
    .CAL_PERIODS(CAL_PERIODS)
  ) u_KnightsTour (
    .clk(clk), .rstN(rstN), .RX(RX), .TX(TX),
    .lftPwm1(lftPwm1), .lftPwm2(lftPwm2),
    .rghtPwm1(rghtPwm1), .rghtPwm2(rghtPwm2)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // PWM edge counters
  //////////////////////////////////////////////////////////////////////

  assign pwmNow = {rghtPwm2, rghtPwm1, lftPwm2, lftPwm1};

  // Index 0 lftPwm1, 1 lftPwm2, 2 rghtPwm1, 3 rghtPwm2
  always @(posedge clk) begin
    pwmPrev <= pwmNow;
    for (int i = 0; i < 4; i++) begin
      if (clearEdges) begin
        edgeCnt[i] <= '0;
      end else if (pwmNow[i] && !pwmPrev[i]) begin
        edgeCnt[i] <= edgeCnt[i] + 16'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////////////////////////

  // One PWM pulse per period, turn is left fwd and right rev
  function automatic outcomeT expectResp(logic [15:0] word);
    outcomeT     e;
    logic [15:0] turnP;
    logic [15:0] driveP;
    e = '0;
    turnP = 16'(word[11:4]) * 16'(TURN_PERIODS);
    driveP = 16'(word[3:0]) * 16'(SQUARE_PERIODS);
    if (word[15:12] == CAL) begin
      e.resp = ACK;
    end else if (word[15:12] == MOVE) begin
      e.resp = ACK;
      e.lft1 = turnP + driveP;
      e.rght1 = driveP;
      e.rght2 = turnP;
    end else if (word[15:12] == SETPOS) begin
      // Echo is 01, then xx, then yy
      e.resp = {2'b01, word[6:4], word[2:0]};
    end else begin
      e.resp = NACK;
    end
    return e;
  endfunction

  task automatic checkValue(string name, logic [15:0] got, logic [15:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  // Compare process, one queued result per clock
  always @(posedge clk) begin
    if (resultQ.size() != 0) begin
      cmpRes = resultQ.pop_front();
      cmpName = nameQ.pop_front();
      cmpExp = expectResp(cmpRes.cmdWord);
      errBefore = errorCount;
      if (cmpRes.gotResp) begin
        checkValue("TX response", {8'h00, cmpRes.seen.resp}, {8'h00, cmpExp.resp});
      end else begin
        errorCount++;
      end
      if (cmpRes.extraResp) begin
        errorCount++;
      end
      checkValue("lftPwm1 edges", cmpRes.seen.lft1, cmpExp.lft1);
      checkValue("lftPwm2 edges", cmpRes.seen.lft2, cmpExp.lft2);
      checkValue("rghtPwm1 edges", cmpRes.seen.rght1, cmpExp.rght1);
      checkValue("rghtPwm2 edges", cmpRes.seen.rght2, cmpExp.rght2);
      testCount++;
      $display("test %0d (%s, cmd %h): %s", testCount, cmpName, cmpRes.cmdWord,
               (errorCount == errBefore) ? "ok" : "mismatch");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Host UART model
  //////////////////////////////////////////////////////////////////////

  // 8N1, each bit BAUD_DIV clocks, LSB first
  task automatic sendByte(logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #2 RX = frame[i];
      repeat (BAUD_DIV - 1) @(posedge clk);
    end
  endtask

  // MSB first
  task automatic sendCmd(logic [15:0] word);
    sendByte(word[15:8]);
    sendByte(word[7:0]);
  endtask

  task automatic recvByte(output logic [7:0] b, output logic ok);
    int waitCnt;
    ok = 1'b0;
    b = '0;
    waitCnt = 0;
    @(negedge clk);
    while (TX !== 1'b0 && waitCnt < RESP_TIMEOUT) begin
      @(negedge clk);
      waitCnt++;
    end
    if (TX !== 1'b0) begin
      $display("timed out at %0t waiting for a response on TX", $time);
      return;
    end
    // Move to mid bit
    repeat (BAUD_DIV / 2) @(negedge clk);
    if (TX !== 1'b0) begin
      $display("response start bit did not hold at %0t", $time);
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BAUD_DIV) @(negedge clk);
      b[i] = TX;
    end
    repeat (BAUD_DIV) @(negedge clk);
    if (TX !== 1'b1) begin
      $display("response stop bit was low at %0t", $time);
      return;
    end
    ok = 1'b1;
  endtask

  // Any start bit here means a second response
  task automatic checkQuiet(output logic seenStart);
    seenStart = 1'b0;
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (TX === 1'b0) begin
        seenStart = 1'b1;
      end
    end
    if (seenStart) begin
      $display("an extra response appeared on TX before %0t", $time);
    end
  endtask

  task automatic runTest(string name, logic [15:0] word, logic sendExtra,
                         logic [15:0] extraWord);
    resultT     r;
    logic [7:0] b;
    logic       ok;
    logic       extra;
    r = '0;
    @(posedge clk);
    #2 clearEdges = 1'b1;
    @(posedge clk);
    #2 clearEdges = 1'b0;
    sendCmd(word);
    // Second command lands while the first is still running
    if (sendExtra) begin
      sendCmd(extraWord);
    end
    recvByte(b, ok);
    r.cmdWord = word;
    r.gotResp = ok;
    r.seen.resp = b;
    r.seen.lft1 = edgeCnt[0];
    r.seen.lft2 = edgeCnt[1];
    r.seen.rght1 = edgeCnt[2];
    r.seen.rght2 = edgeCnt[3];
    checkQuiet(extra);
    r.extraResp = extra;
    resultQ.push_back(r);
    nameQ.push_back(name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [3:0]  op;
    int          drainCnt;
    RX = 1'b1;
    rstN = 1'b0;
    clearEdges = 1'b0;
    drainFailed = 1'b0;
    seed = 68204;
    repeat (8) @(posedge clk);
    #2 rstN = 1'b1;
    repeat (4) @(posedge clk);

    runTest("calibrate", {CAL, 12'h000}, 1'b0, '0);
    runTest("move h3 s4", {MOVE, 8'd3, 4'd4}, 1'b0, '0);
    runTest("move h0 s2", {MOVE, 8'd0, 4'd2}, 1'b0, '0);
    runTest("move h2 s0", {MOVE, 8'd2, 4'd0}, 1'b0, '0);
    // Reserved bits random too
    for (int i = 0; i < 3; i++) begin
      rnd = $random(seed);
      runTest("set position", {SETPOS, rnd[11:0]}, 1'b0, '0);
    end
    // Known opcodes flipped to a neighbour that is not
    for (int i = 0; i < 3; i++) begin
      rnd = $random(seed);
      op = rnd[15:12];
      if (op == CAL || op == MOVE || op == SETPOS) begin
        op = op ^ 4'h1;
      end
      runTest("invalid opcode", {op, rnd[11:0]}, 1'b0, '0);
    end
    runTest("dropped command", {MOVE, 8'd3, 4'd4}, 1'b1, {SETPOS, 12'h0A5});

    for (drainCnt = 0; drainCnt < 100 && resultQ.size() != 0; drainCnt++) begin
      @(posedge clk);
    end
    if (resultQ.size() != 0) begin
      $display("compare process left %0d results unchecked", resultQ.size());
      drainFailed = 1'b1;
    end
    repeat (2) @(posedge clk);
    assertFails = u_KnightsTour.uCmdProc.uAssertions.revFails
                + u_KnightsTour.uCmdProc.uAssertions.startFails
                + u_KnightsTour.uCmdProc.uAssertions.idleFails;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             testCount, checkCount, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0 && !drainFailed) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/knightsTour_assertions.sv */
`default_nettype none

module knightsTour_assertions
  import linkPkg::*;
(
  input logic       clk,
  input logic       rstN,
  input driveT      lftDrive,
  input driveT      rghtDrive,
  input logic       txStart,
  input logic       txBusy,
  input logic [2:0] state
);

  // Idle is the first entry of the cmdProc state enum
  localparam logic [2:0] IDLE_CODE = 3'd0;

  // Failure tallies, read by the testbench at the end of the run
  int unsigned revFails = 0;
  int unsigned startFails = 0;
  int unsigned idleFails = 0;

  // A turn spins one wheel backwards, never both
  noDoubleReverse: assert property (@(posedge clk) disable iff (!rstN)
      !(lftDrive.dir == REV && rghtDrive.dir == REV))
    else begin
      $error("both wheel drives are in reverse");
      revFails++;
    end

  // Response strobe only when the transmitter is free
  txStartWhenFree: assert property (@(posedge clk) disable iff (!rstN)
      !(txStart && txBusy))
    else begin
      $error("txStart raised while the transmitter is busy");
      startFails++;
    end

  // Motors rest between commands
  stopWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
      (state == IDLE_CODE) |-> (lftDrive.dir == STOP && rghtDrive.dir == STOP))
    else begin
      $error("a wheel is driven while the sequencer is idle");
      idleFails++;
    end

endmodule

bind cmdProc knightsTour_assertions uAssertions (
  .clk(clk),
  .rstN(rstN),
  .lftDrive(lftDrive),
  .rghtDrive(rghtDrive),
  .txStart(txStart),
  .txBusy(txBusy),
  .state(state)
);

`default_nettype wire

/* hw/KnightsTour.sv */
`default_nettype none

module KnightsTour
  import cmdPkg::*;
  import linkPkg::*;
#(
  parameter int BAUD_DIV       = 16,
  parameter int PWM_BITS       = 6,
  parameter int DRIVE_DUTY     = 40,
  parameter int TURN_PERIODS   = 2,
  parameter int SQUARE_PERIODS = 3,
  parameter int CAL_PERIODS    = 4
) (
  input  logic clk,
  input  logic rstN,
  input  logic RX,
  output logic TX,
  output logic lftPwm1,
  output logic lftPwm2,
  output logic rghtPwm1,
  output logic rghtPwm2
);

  logic [7:0] rxByte;
  logic       rxRdy;
  cmdWordT    cmd;
  logic       cmdRdy;
  driveT      lftDrive;
  driveT      rghtDrive;
  logic       periodStart;
  logic [7:0] txByte;
  logic       txStart;
  logic       txBusy;

  //////////////////////////////////////////////////////////////////////
  // Host link
  //////////////////////////////////////////////////////////////////////

  uartRx #(.BAUD_DIV(BAUD_DIV)) uUartRx (
    .clk(clk), .rstN(rstN), .RX(RX), .rxByte(rxByte), .rxRdy(rxRdy)
  );

  cmdAssembler uCmdAssembler (
    .clk(clk), .rstN(rstN), .rxByte(rxByte), .rxRdy(rxRdy),
    .cmd(cmd), .cmdRdy(cmdRdy)
  );

  uartTx #(.BAUD_DIV(BAUD_DIV)) uUartTx (
    .clk(clk), .rstN(rstN), .txByte(txByte), .txStart(txStart),
    .TX(TX), .txBusy(txBusy)
  );

  //////////////////////////////////////////////////////////////////////
  // Control and wheels
  //////////////////////////////////////////////////////////////////////

  cmdProc #(
    .TURN_PERIODS(TURN_PERIODS),
    .SQUARE_PERIODS(SQUARE_PERIODS),
    .CAL_PERIODS(CAL_PERIODS)
  ) uCmdProc (
    .clk(clk), .rstN(rstN), .cmd(cmd), .cmdRdy(cmdRdy),
    .periodStart(periodStart), .txBusy(txBusy),
    .lftDrive(lftDrive), .rghtDrive(rghtDrive),
    .txByte(txByte), .txStart(txStart)
  );

  // Left wheel paces the sequencer
  motorPwm #(.PWM_BITS(PWM_BITS), .DRIVE_DUTY(DRIVE_DUTY)) uLftPwm (
    .clk(clk), .rstN(rstN), .drive(lftDrive),
    .pwm1(lftPwm1), .pwm2(lftPwm2), .periodStart(periodStart)
  );

  // Same counter phase as the left one, its pulse is not needed
  motorPwm #(.PWM_BITS(PWM_BITS), .DRIVE_DUTY(DRIVE_DUTY)) uRghtPwm (
    .clk(clk), .rstN(rstN), .drive(rghtDrive),
    .pwm1(rghtPwm1), .pwm2(rghtPwm2), .periodStart()
  );

endmodule

`default_nettype wire

/* hw/cmdAssembler.sv */
`default_nettype none

module cmdAssembler
  import cmdPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic [7:0] rxByte,
  input  logic       rxRdy,
  output cmdWordT    cmd,
  output logic       cmdRdy
);

  logic [7:0] highByte;
  // Set once the MSB of the pair has been taken
  logic       haveHigh;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      haveHigh <= 1'b0;
      cmdRdy   <= 1'b0;
    end else begin
      cmdRdy <= 1'b0;
      if (rxRdy) begin
        haveHigh <= !haveHigh;
        cmdRdy   <= haveHigh;
      end
    end
  end

  // Word is complete on the second byte
  always_ff @(posedge clk) begin
    if (rxRdy) begin
      if (haveHigh) begin
        cmd <= {highByte, rxByte};
      end else begin
        highByte <= rxByte;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/cmdPkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Command word layout and response codes
//////////////////////////////////////////////////////////////////////

package cmdPkg;

  // Opcode sits in the top nibble of every command word
  // Values outside this set are answered with NACK
  typedef enum logic [3:0] {
    CAL    = 4'h2,
    MOVE   = 4'h4,
    SETPOS = 4'h6
  } opcodeT;

  // Move view of the word
  // Heading in turn units, then squares to travel
  typedef struct packed {
    opcodeT     opcode;
    logic [7:0] heading;
    logic [3:0] squares;
  } moveCmdT;

  // Set-position view of the word
  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rsvdHi;
    logic [2:0] xx;
    logic       rsvdLo;
    logic [2:0] yy;
  } posCmdT;

  // One 16-bit word, read through whichever view the opcode selects
  typedef union packed {
    moveCmdT mv;
    posCmdT  pos;
  } cmdWordT;

  // Response bytes
  localparam logic [7:0] ACK  = 8'hA5;
  localparam logic [7:0] NACK = 8'hEE;

  // Top two bits of the set-position echo, followed by xx and yy
  localparam logic [1:0] ECHO_TAG = 2'b01;

endpackage

`default_nettype wire

/* hw/cmdProc.sv */
`default_nettype none

module cmdProc
  import cmdPkg::*;
  import linkPkg::*;
#(
  parameter int TURN_PERIODS   = 2,
  parameter int SQUARE_PERIODS = 3,
  parameter int CAL_PERIODS    = 4
) (
  input  logic       clk,
  input  logic       rstN,
  input  cmdWordT    cmd,
  input  logic       cmdRdy,
  input  logic       periodStart,
  input  logic       txBusy,
  output driveT      lftDrive,
  output driveT      rghtDrive,
  output logic [7:0] txByte,
  output logic       txStart
);

  // Wide enough for 255 units times the largest period factor
  localparam int CNT_W = 8 + $clog2(TURN_PERIODS + SQUARE_PERIODS + CAL_PERIODS + 1);

  typedef enum logic [2:0] {
    IDLE,
    CALIB,
    TURN,
    DRIVE,
    RESPOND,
    WAIT_TX
  } stateT;

  stateT            state;
  logic [CNT_W-1:0] periodCnt;
  logic [CNT_W-1:0] turnLen;
  logic [CNT_W-1:0] driveLen;
  logic [CNT_W-1:0] drivePeriods;
  logic [7:0]       respCode;
  logic             echoSel;
  logic [5:0]       curPos;
  logic             accept;
  logic             txReady;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  // Anything arriving outside idle is dropped
  assign accept = cmdRdy && (state == IDLE);
  // Also covers the cycle txStart is up but busy not yet set
  assign txReady = !txBusy && !txStart;

  // Phase lengths in whole PWM periods
  assign turnLen  = CNT_W'(cmd.mv.heading) * CNT_W'(TURN_PERIODS);
  assign driveLen = CNT_W'(cmd.mv.squares) * CNT_W'(SQUARE_PERIODS);

  // Captured on accept, the assembler may overwrite cmd mid-move
  always_ff @(posedge clk) begin
    if (accept) begin
      drivePeriods <= driveLen;
      echoSel      <= (cmd.mv.opcode == SETPOS);
      respCode     <= (cmd.mv.opcode == CAL || cmd.mv.opcode == MOVE) ? ACK : NACK;
      if (cmd.pos.opcode == SETPOS) begin
        curPos <= {cmd.pos.xx, cmd.pos.yy};
      end
    end
  end

  // Echo of the stored square, or the plain code
  assign txByte = echoSel ? {ECHO_TAG, curPos} : respCode;

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  // periodStart marks the cycle where the motor latches its drive,
  // so each one seen in a phase state commits one period of that phase
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= IDLE;
      periodCnt <= '0;
      txStart   <= 1'b0;
    end else begin
      txStart <= 1'b0;
      case (state)
        IDLE: begin
          if (cmdRdy) begin
            case (cmd.mv.opcode)
              CAL: begin
                state     <= CALIB;
                periodCnt <= CNT_W'(CAL_PERIODS);
              end
              MOVE: begin
                // Zero-length phases are skipped outright
                if (turnLen != '0) begin
                  state     <= TURN;
                  periodCnt <= turnLen;
                end else if (driveLen != '0) begin
                  state     <= DRIVE;
                  periodCnt <= driveLen;
                end else begin
                  state <= RESPOND;
                end
              end
              // Set-position and invalid answer right away
              default: begin
                if (txReady) begin
                  txStart <= 1'b1;
                end else begin
                  state <= WAIT_TX;
                end
              end
            endcase
          end
        end
        CALIB, TURN, DRIVE: begin
          if (periodStart) begin
            if (periodCnt > CNT_W'(1)) begin
              periodCnt <= periodCnt - 1'b1;
            end else if (state == TURN && drivePeriods != '0) begin
              state     <= DRIVE;
              periodCnt <= drivePeriods;
            end else begin
              state <= RESPOND;
            end
          end
        end
        // Last active period ends at the next wrap, motors latch stop
        RESPOND: begin
          if (periodStart) begin
            state <= WAIT_TX;
          end
        end
        // Hold off until the transmitter is free
        WAIT_TX: begin
          if (txReady) begin
            txStart <= 1'b1;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Turn spins in place, left forward and right reverse
  always_comb begin
    lftDrive.dir  = STOP;
    rghtDrive.dir = STOP;
    case (state)
      TURN: begin
        lftDrive.dir  = FWD;
        rghtDrive.dir = REV;
      end
      DRIVE: begin
        lftDrive.dir  = FWD;
        rghtDrive.dir = FWD;
      end
      default: begin
        lftDrive.dir  = STOP;
        rghtDrive.dir = STOP;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/linkPkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Serial framing and motor drive types
//////////////////////////////////////////////////////////////////////

package linkPkg;

  // Line levels of an 8N1 frame
  localparam logic IDLE_LEVEL = 1'b1;
  localparam logic START_BIT  = 1'b0;
  localparam logic STOP_BIT   = 1'b1;

  // One frame as it leaves the shifter, start bit first (LSB)
  typedef struct packed {
    logic       stopBit;
    logic [7:0] data;
    logic       startBit;
  } uartFrameT;

  localparam int FRAME_BITS = $bits(uartFrameT);

  // Wheel direction
  typedef enum logic [1:0] {
    STOP = 2'b00,
    FWD  = 2'b01,
    REV  = 2'b10
  } dirT;

  typedef struct packed {
    dirT dir;
  } driveT;

endpackage

`default_nettype wire

/* hw/motorPwm.sv */
`default_nettype none

module motorPwm
  import linkPkg::*;
#(
  parameter int PWM_BITS   = 6,
  parameter int DRIVE_DUTY = 40
) (
  input  logic  clk,
  input  logic  rstN,
  input  driveT drive,
  output logic  pwm1,
  output logic  pwm2,
  output logic  periodStart
);

  logic [PWM_BITS-1:0] pwmCnt;
  // Direction in force for the current period
  driveT               activeDrive;
  logic                highTime;

  // Last count before the wrap, the new period begins on the next edge
  assign periodStart = (pwmCnt == '1);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pwmCnt          <= '0;
      activeDrive.dir <= STOP;
    end else begin
      pwmCnt <= pwmCnt + 1'b1;
      // Only whole pulses reach the pins
      if (periodStart) begin
        activeDrive <= drive;
      end
    end
  end

  // High for counts 0 up to DRIVE_DUTY - 1
  assign highTime = 32'(pwmCnt) < DRIVE_DUTY;

  // Forward on pwm1, reverse on pwm2, stop keeps both low
  assign pwm1 = highTime && (activeDrive.dir == FWD);
  assign pwm2 = highTime && (activeDrive.dir == REV);

endmodule

`default_nettype wire

/* hw/uartRx.sv */
`default_nettype none

module uartRx
  import linkPkg::*;
#(
  parameter int BAUD_DIV = 16
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic       RX,
  output logic [7:0] rxByte,
  output logic       rxRdy
);

  localparam int CNT_W = $clog2(BAUD_DIV) + 1;
  // First wait lands in the middle of the start bit
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(BAUD_DIV / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(BAUD_DIV - 1);
  localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 1);

  logic             rxMeta;
  logic             rxSync;
  logic             rxPrev;
  logic             busy;
  logic [CNT_W-1:0] baudCnt;
  logic [3:0]       bitIdx;
  logic             sampleNow;
  logic             startEdge;
  logic [7:0]       shiftReg;

  // Two flops against metastability, third for edge detect
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxMeta <= IDLE_LEVEL;
      rxSync <= IDLE_LEVEL;
      rxPrev <= IDLE_LEVEL;
    end else begin
      rxMeta <= RX;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  assign startEdge = (rxPrev == IDLE_LEVEL) && (rxSync == START_BIT);
  assign sampleNow = busy && (baudCnt == '0);

  // Bit timing, index 0 is the start bit, LAST_BIT the stop bit
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy    <= 1'b0;
      baudCnt <= '0;
      bitIdx  <= '0;
      rxRdy   <= 1'b0;
    end else begin
      rxRdy <= 1'b0;
      if (!busy) begin
        if (startEdge) begin
          busy    <= 1'b1;
          baudCnt <= HALF_BIT;
          bitIdx  <= '0;
        end
      end else if (!sampleNow) begin
        baudCnt <= baudCnt - 1'b1;
      end else begin
        baudCnt <= FULL_BIT;
        bitIdx  <= bitIdx + 1'b1;
        // Glitch on the line, start bit gone by mid-bit
        if (bitIdx == '0 && rxSync != START_BIT) begin
          busy <= 1'b0;
        end
        // Bad stop bit drops the frame silently
        if (bitIdx == LAST_BIT) begin
          busy  <= 1'b0;
          rxRdy <= (rxSync == STOP_BIT);
        end
      end
    end
  end

  // Data arrives LSB first, shift in from the top
  always_ff @(posedge clk) begin
    if (sampleNow && bitIdx != '0 && bitIdx != LAST_BIT) begin
      shiftReg <= {rxSync, shiftReg[7:1]};
    end
  end

  assign rxByte = shiftReg;

endmodule

`default_nettype wire

/* hw/uartTx.sv */
`default_nettype none

module uartTx
  import linkPkg::*;
#(
  parameter int BAUD_DIV = 16
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic [7:0] txByte,
  input  logic       txStart,
  output logic       TX,
  output logic       txBusy
);

  localparam int CNT_W = $clog2(BAUD_DIV) + 1;
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(BAUD_DIV - 1);
  localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 1);

  uartFrameT             frame;
  logic [FRAME_BITS-1:0] shiftReg;
  logic [CNT_W-1:0]      baudCnt;
  logic [3:0]            bitIdx;

  assign frame = '{stopBit: STOP_BIT, data: txByte, startBit: START_BIT};

  // Bit 0 of the shifter is the line, so reset leaves TX idle high
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      txBusy   <= 1'b0;
      baudCnt  <= '0;
      bitIdx   <= '0;
      shiftReg <= {FRAME_BITS{IDLE_LEVEL}};
    end else if (!txBusy) begin
      if (txStart) begin
        txBusy   <= 1'b1;
        shiftReg <= frame;
        baudCnt  <= FULL_BIT;
        bitIdx   <= '0;
      end
    end else if (baudCnt != '0) begin
      baudCnt <= baudCnt - 1'b1;
    end else if (bitIdx == LAST_BIT) begin
      // Stop bit has had its full time
      txBusy <= 1'b0;
    end else begin
      // Idle level fills in behind the frame
      shiftReg <= {IDLE_LEVEL, shiftReg[FRAME_BITS-1:1]};
      bitIdx   <= bitIdx + 1'b1;
      baudCnt  <= FULL_BIT;
    end
  end

  assign TX = shiftReg[0];

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge by the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module KnightsTour_tb -f sim.f -o simKnightsTour \
  || { echo "Verilator build failed"; exit 1; }

# Keep running past assertion errors so the testbench can report them
./obj_dir/simKnightsTour +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sim.f */
hw/cmdPkg.sv
hw/linkPkg.sv
hw/uartRx.sv
hw/uartTx.sv
hw/cmdAssembler.sv
hw/cmdProc.sv
hw/motorPwm.sv
hw/KnightsTour.sv
bench/knightsTour_assertions.sv
bench/KnightsTour_tb.sv
